/* lcdTests.txt */
# Command letter, hex fields: W adr data bytestrobes, F adr data, R adr expected, I irq
# E count bytes..., P scl sda, C cycles, D waits for idle
R 0 0
R 1 0
R 3 3c
R 7 0
P 1 1
I 0
W 4 ffa4f123 f
R 4 00a40123
W 1 e 1
R 1 e
W 1 0 1
W 3 55 e
R 3 3c
W 3 12 f
R 3 12
W 3 3c 1
F 004 44332211
F 1ff a4a3a2a1
F 200 b4b3b2b1
W 4 000407fe 1
W 1 1 1
E 6 78 40 a3 a4 b1 b2
D
I 0
R 1 8
R 0 2
W 1 0 1
R 1 0
W 4 00030011 1
W 1 5 1
E 5 78 40 22 33 44
D
I 1
R 1 c
W 1 4 1
I 0
R 1 4
W 4 00020010 1
W 1 3 1
E 4 78 40 11 22
C 20
W 1 0 1
E 4 78 40 11 22
D
C 100
R 1 8
I 0
P 1 1
W 4 00000010 1
W 1 1 1
E 2 78 40
D
R 1 8
P 1 1

/* list.f */
lcdRegPkg.sv
lcdLinkPkg.sv
lcdFrameBuffer.sv
lcdRegisters.sv
lcdLoadEngine.sv
lcdSerialTx.sv
lcdControllerTop.sv
tbLcdController.sv

/* tbLcdController.sv */
// Testbench for the panel controller, replays lcdTests.txt and decodes the two-wire panel link
`timescale 1ns/10ps

module tbLcdController
    import lcdRegPkg::*;
    import lcdLinkPkg::*;
();

    logic     wbClk;
    logic     wbRst;
    wbAdr_t   wbAdr;
    logic     wbCyc;
    logic     wbFbCyc;
    logic     wbStb;
    logic     wbWe;
    byteStb_t wbByteStb;
    wbDat_t   wbDatIn;
    wbDat_t   wbDatOut;
    logic     wbAck;
    logic     wbFbAck;
    logic     loadIrq;
    logic     lcdScl;
    logic     lcdSda;

    // Parsed test file, commands and their hex arguments in order
    byte       cmdQ [$];
    wbDat_t    argQ [$];

    // Decoded panel traffic
    linkByte_t rxBytes [$];
    int        frameLens [$];
    logic      inFrame;

    // Set once the test file is parsed
    int        limitCycles = 0;

    lcdControllerTop dut_i (
        .WBs_CLK_i      (wbClk),
        .WBs_RST_i      (wbRst),
        .WBs_ADR_i      (wbAdr),
        .WBs_CYC_i      (wbCyc),
        .WBs_FB_CYC_i   (wbFbCyc),
        .WBs_STB_i      (wbStb),
        .WBs_WE_i       (wbWe),
        .WBs_BYTE_STB_i (wbByteStb),
        .WBs_DAT_i      (wbDatIn),
        .WBs_DAT_o      (wbDatOut),
        .WBs_ACK_o      (wbAck),
        .WBs_FB_ACK_o   (wbFbAck),
        .lcdLoadIrq_o   (loadIrq),
        .lcdScl_o       (lcdScl),
        .lcdSda_o       (lcdSda)
    );

    // 8 ns clock
    initial
    begin
        wbClk = 1'b0;
        forever #4 wbClk = ~wbClk;
    end

    // ------------------------------------------------------------------------
    // Error handling and checks
    // ------------------------------------------------------------------------
    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
            stopOnError($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                  name, actual, expected));
    endtask

    // ------------------------------------------------------------------------
    // Test file parsing
    // ------------------------------------------------------------------------
    task automatic readArgs(input int fd, input int count);
        wbDat_t value;
        int     got;
        for (int i = 0; i < count; i++)
        begin
            got = $fscanf(fd, "%h", value);
            if (got != 1)
                stopOnError("a line of the test file is missing a value");
            argQ.push_back(value);
        end
    endtask

    // Rest of a comment line
    task automatic skipLine(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1)
            ch = $fgetc(fd);
    endtask

    // ------------------------------------------------------------------------
    // Host bus accesses, two cycles each plus one idle cycle
    // ------------------------------------------------------------------------
    task automatic writeWord(input logic toFb, input wbAdr_t adr, input wbDat_t data,
                             input byteStb_t stb);
        @(posedge wbClk);
        wbAdr     <= adr;
        wbDatIn   <= data;
        wbByteStb <= stb;
        wbWe      <= 1'b1;
        wbStb     <= 1'b1;
        wbCyc     <= ~toFb;
        wbFbCyc   <= toFb;
        // Acknowledge due one cycle after the strobe, looked at mid-cycle
        @(posedge wbClk);
        @(negedge wbClk);
        checkValue("WBs_ACK_o", wbAck, toFb ? 1'b0 : 1'b1);
        checkValue("WBs_FB_ACK_o", wbFbAck, toFb ? 1'b1 : 1'b0);
        @(posedge wbClk);
        wbCyc   <= 1'b0;
        wbFbCyc <= 1'b0;
        wbStb   <= 1'b0;
        wbWe    <= 1'b0;
    endtask

    task automatic readRegister(input wbAdr_t adr, output wbDat_t data);
        @(posedge wbClk);
        wbAdr     <= adr;
        wbByteStb <= 4'hF;
        wbWe      <= 1'b0;
        wbStb     <= 1'b1;
        wbCyc     <= 1'b1;
        @(posedge wbClk);
        @(negedge wbClk);
        checkValue("WBs_ACK_o", wbAck, 1'b1);
        checkValue("WBs_FB_ACK_o", wbFbAck, 1'b0);
        // Read data is combinational from the held address
        data = wbDatOut;
        @(posedge wbClk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Serial monitor
    // Bit sampled at SCL rise, taken at the following fall, so the SCL pulse
    // ahead of a stop never counts as data
    // ------------------------------------------------------------------------
    initial
    begin
        logic      sclPrev;
        logic      sdaPrev;
        logic      bitPending;
        logic      sampledBit;
        int        bitCount;
        int        frameBytes;
        linkByte_t shiftByte;

        sclPrev    = 1'b1;
        sdaPrev    = 1'b1;
        inFrame    = 1'b0;
        bitPending = 1'b0;
        sampledBit = 1'b0;
        bitCount   = 0;
        frameBytes = 0;
        shiftByte  = '0;
        forever
        begin
            @(negedge wbClk);
            if (sclPrev && lcdScl && sdaPrev && !lcdSda)
            begin
                // Start, SDA falls under high SCL
                if (inFrame)
                    stopOnError("start condition inside an open transaction, stop missing");
                inFrame    = 1'b1;
                bitPending = 1'b0;
                bitCount   = 0;
                frameBytes = 0;
            end
            else if (sclPrev && lcdScl && !sdaPrev && lcdSda)
            begin
                // Stop, SDA rises under high SCL
                if (!inFrame)
                    stopOnError("stop condition seen without a start condition");
                if (bitCount != 0)
                    stopOnError("stop condition in the middle of a byte");
                inFrame = 1'b0;
                frameLens.push_back(frameBytes);
            end
            else if (!sclPrev && lcdScl)
            begin
                if (!inFrame)
                    stopOnError("serial clock pulse without a start condition");
                sampledBit = lcdSda;
                bitPending = 1'b1;
            end
            else if (sclPrev && !lcdScl && bitPending)
            begin
                bitPending = 1'b0;
                // Ninth bit is the released acknowledge slot
                if (bitCount < 8)
                    shiftByte = {shiftByte[6:0], sampledBit};
                bitCount = bitCount + 1;
                if (bitCount == 8)
                begin
                    rxBytes.push_back(shiftByte);
                    frameBytes = frameBytes + 1;
                end
                else if (bitCount == 9)
                    bitCount = 0;
            end
            sclPrev = lcdScl;
            sdaPrev = lcdSda;
        end
    end

    // Watchdog, 72 clocks per expected byte with a margin of two
    initial
    begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge wbClk);
        stopOnError("watchdog expired before the test file was finished");
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial
    begin
        int     fd;
        int     n;
        int     frameLen;
        int     totalBytes;
        byte    cmd;
        wbDat_t a;
        wbDat_t d;
        wbDat_t s;
        wbDat_t rdData;
        wbDat_t rxByte;

        wbRst     = 1'b1;
        wbAdr     = '0;
        wbCyc     = 1'b0;
        wbFbCyc   = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbByteStb = '0;
        wbDatIn   = '0;

        // Whole file parsed first, the watchdog needs the byte total
        totalBytes = 0;
        fd = $fopen("lcdTests.txt", "r");
        if (fd == 0)
            stopOnError("cannot open the test file lcdTests.txt");
        while ($fscanf(fd, " %c", cmd) == 1)
        begin
            if (cmd == "#")
                skipLine(fd);
            else
            begin
                cmdQ.push_back(cmd);
                case (cmd)
                    "W":
                        readArgs(fd, 3);
                    "F", "R", "P":
                        readArgs(fd, 2);
                    "I", "C":
                        readArgs(fd, 1);
                    "D":
                    begin
                    end
                    "E":
                    begin
                        readArgs(fd, 1);
                        n = argQ[argQ.size() - 1];
                        totalBytes = totalBytes + n;
                        readArgs(fd, n);
                    end
                    default:
                        stopOnError($sformatf("unknown command %c in the test file", cmd));
                endcase
            end
        end
        $fclose(fd);
        limitCycles = totalBytes * 72 * 2 + 2000;

        repeat (8) @(posedge wbClk);
        wbRst <= 1'b0;

        while (cmdQ.size() > 0)
        begin
            cmd = cmdQ.pop_front();
            case (cmd)
                "W":
                begin
                    a = argQ.pop_front();
                    d = argQ.pop_front();
                    s = argQ.pop_front();
                    writeWord(1'b0, wbAdr_t'(a), d, byteStb_t'(s));
                end
                "F":
                begin
                    a = argQ.pop_front();
                    d = argQ.pop_front();
                    writeWord(1'b1, wbAdr_t'(a), d, 4'hF);
                end
                "R":
                begin
                    a = argQ.pop_front();
                    d = argQ.pop_front();
                    readRegister(wbAdr_t'(a), rdData);
                    checkValue($sformatf("WBs_DAT_o at 0x%0h", a), rdData, d);
                end
                "E":
                begin
                    n = argQ.pop_front();
                    while (frameLens.size() == 0)
                        @(posedge wbClk);
                    frameLen = frameLens.pop_front();
                    checkValue("transaction byte count", frameLen, n);
                    for (int i = 0; i < n; i++)
                    begin
                        d      = argQ.pop_front();
                        rxByte = rxBytes.pop_front();
                        checkValue($sformatf("lcdSda_o byte %0d", i), rxByte, d);
                    end
                end
                "I":
                begin
                    a = argQ.pop_front();
                    checkValue("lcdLoadIrq_o", loadIrq, a);
                end
                "P":
                begin
                    a = argQ.pop_front();
                    d = argQ.pop_front();
                    checkValue("lcdScl_o", lcdScl, a);
                    checkValue("lcdSda_o", lcdSda, d);
                end
                "C":
                begin
                    a = argQ.pop_front();
                    repeat (a) @(posedge wbClk);
                end
                default:
                begin
                    // Poll busy, then one cycle for the done flag to land
                    readRegister(StatusRegAdr, rdData);
                    while (rdData[0] !== 1'b0)
                        readRegister(StatusRegAdr, rdData);
                    @(posedge wbClk);
                end
            endcase
        end

        // Nothing left on the link
        checkValue("unchecked transactions", frameLens.size(), 0);
        if (inFrame)
            stopOnError("transaction left open at the end, stop condition missing");
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* lcdControllerTop.sv */
// Panel controller top: joins the register block, frame memory, load engine and transmitter
`timescale 1ns/10ps

module lcdControllerTop
    import lcdRegPkg::*;
    import lcdLinkPkg::*;
(
    input  logic     WBs_CLK_i,
    input  logic     WBs_RST_i,
    input  wbAdr_t   WBs_ADR_i,
    input  logic     WBs_CYC_i,
    input  logic     WBs_FB_CYC_i,
    input  logic     WBs_STB_i,
    input  logic     WBs_WE_i,
    input  byteStb_t WBs_BYTE_STB_i,
    input  wbDat_t   WBs_DAT_i,
    output wbDat_t   WBs_DAT_o,
    output logic     WBs_ACK_o,
    output logic     WBs_FB_ACK_o,
    output logic     lcdLoadIrq_o,
    output logic     lcdScl_o,
    output logic     lcdSda_o
);

    // Register settings
    logic      ctrlEn;
    logic      autoRefresh;
    slvAdr_t   slvAdr;
    fbRdAdr_t  winStart;
    loadLen_t  winLen;

    // Engine status
    logic      busy;
    logic      loadDone;
    logic      loadClr;

    // Frame memory ports
    fbWrAdr_t  fbWrAdr;
    wbDat_t    fbWrDat;
    logic      fbWrEn1;
    logic      fbWrEn2;
    fbRdAdr_t  fbRdAdr;
    linkByte_t fbRdDat;

    // Byte handoff
    linkByte_t txByte;
    logic      txLast;
    logic      txSend;
    logic      txReady;

    lcdRegisters u_lcdRegisters (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .WBs_ADR_i      (WBs_ADR_i),
        .WBs_CYC_i      (WBs_CYC_i),
        .WBs_FB_CYC_i   (WBs_FB_CYC_i),
        .WBs_STB_i      (WBs_STB_i),
        .WBs_WE_i       (WBs_WE_i),
        .WBs_BYTE_STB_i (WBs_BYTE_STB_i),
        .WBs_DAT_i      (WBs_DAT_i),
        .busy_i         (busy),
        .loadDone_i     (loadDone),
        .loadClr_i      (loadClr),
        .WBs_DAT_o      (WBs_DAT_o),
        .WBs_ACK_o      (WBs_ACK_o),
        .WBs_FB_ACK_o   (WBs_FB_ACK_o),
        .ctrlEn_o       (ctrlEn),
        .autoRefresh_o  (autoRefresh),
        .slvAdr_o       (slvAdr),
        .winStart_o     (winStart),
        .winLen_o       (winLen),
        .fbWrAdr_o      (fbWrAdr),
        .fbWrDat_o      (fbWrDat),
        .fbWrEn1_o      (fbWrEn1),
        .fbWrEn2_o      (fbWrEn2),
        .lcdLoadIrq_o   (lcdLoadIrq_o)
    );

    lcdFrameBuffer u_lcdFrameBuffer (
        .WBs_CLK_i (WBs_CLK_i),
        .fbWrAdr_i (fbWrAdr),
        .fbWrDat_i (fbWrDat),
        .fbWrEn1_i (fbWrEn1),
        .fbWrEn2_i (fbWrEn2),
        .fbRdAdr_i (fbRdAdr),
        .fbRdDat_o (fbRdDat)
    );

    lcdLoadEngine u_lcdLoadEngine (
        .WBs_CLK_i     (WBs_CLK_i),
        .WBs_RST_i     (WBs_RST_i),
        .ctrlEn_i      (ctrlEn),
        .autoRefresh_i (autoRefresh),
        .slvAdr_i      (slvAdr),
        .winStart_i    (winStart),
        .winLen_i      (winLen),
        .fbRdDat_i     (fbRdDat),
        .txReady_i     (txReady),
        .busy_o        (busy),
        .loadDone_o    (loadDone),
        .loadClr_o     (loadClr),
        .fbRdAdr_o     (fbRdAdr),
        .txByte_o      (txByte),
        .txLast_o      (txLast),
        .txSend_o      (txSend)
    );

    lcdSerialTx u_lcdSerialTx (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .txByte_i  (txByte),
        .txLast_i  (txLast),
        .txSend_i  (txSend),
        .txReady_o (txReady),
        .lcdScl_o  (lcdScl_o),
        .lcdSda_o  (lcdSda_o)
    );

endmodule

/* lcdSerialTx.sv */
// Two-wire panel transmitter: start, MSB-first bytes with a released ninth bit, then stop
`timescale 1ns/10ps

module lcdSerialTx
    import lcdLinkPkg::*;
(
    input  logic      WBs_CLK_i,
    input  logic      WBs_RST_i,
    input  linkByte_t txByte_i,
    input  logic      txLast_i,
    input  logic      txSend_i,
    output logic      txReady_o,
    output logic      lcdScl_o,
    output logic      lcdSda_o
);

    txState_t               txState;
    logic [QuarterCntW-1:0] qCnt;
    logic [1:0]             phase;
    logic [3:0]             bitCnt;
    linkByte_t              shiftReg;
    logic                   lastByte;
    // Start already sent, SCL parked low between bytes
    logic                   frameOpen;

    // ------------------------------------------------------------------------
    // Bit timing
    // Phase 0 SCL low and SDA set, phase 1-2 SCL high, phase 3 SCL low
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            txState   <= TxIdle;
            qCnt      <= '0;
            phase     <= '0;
            bitCnt    <= '0;
            shiftReg  <= '0;
            lastByte  <= 1'b0;
            frameOpen <= 1'b0;
            txReady_o <= 1'b1;
            lcdScl_o  <= 1'b1;
            lcdSda_o  <= 1'b1;
        end
        else if (txState == TxIdle)
        begin
            qCnt   <= '0;
            phase  <= '0;
            bitCnt <= '0;
            if (txSend_i)
            begin
                shiftReg  <= txByte_i;
                lastByte  <= txLast_i;
                txReady_o <= 1'b0;
                if (frameOpen)
                begin
                    // SCL already low, present the first bit now
                    lcdSda_o <= txByte_i[7];
                    txState  <= TxBit;
                end
                else
                    txState <= TxStart;
            end
        end
        else if (qCnt != QuarterCntW'(QuarterClks - 1))
            qCnt <= qCnt + 1'b1;
        else
        begin
            qCnt  <= '0;
            phase <= phase + 1'b1;
            case (phase)
                2'd0:
                begin
                    lcdScl_o <= 1'b1;
                    // SDA falls under high SCL
                    if (txState == TxStart)
                        lcdSda_o <= 1'b0;
                end
                2'd2:
                begin
                    // SDA rises under high SCL
                    if (txState == TxStop)
                        lcdSda_o <= 1'b1;
                    else
                        lcdScl_o <= 1'b0;
                end
                2'd3:
                begin
                    // End of the current bit period
                    case (txState)
                        TxStart:
                        begin
                            frameOpen <= 1'b1;
                            lcdSda_o  <= shiftReg[7];
                            txState   <= TxBit;
                        end
                        TxBit:
                        if (bitCnt == 4'(FrameBits - 1))
                        begin
                            if (lastByte)
                            begin
                                lcdSda_o <= 1'b0;
                                txState  <= TxStop;
                            end
                            else
                            begin
                                txReady_o <= 1'b1;
                                txState   <= TxIdle;
                            end
                        end
                        else
                        begin
                            // Ones shift in, so the ninth bit is released
                            bitCnt   <= bitCnt + 1'b1;
                            shiftReg <= {shiftReg[6:0], 1'b1};
                            lcdSda_o <= shiftReg[6];
                        end
                        default:
                        begin
                            frameOpen <= 1'b0;
                            txReady_o <= 1'b1;
                            txState   <= TxIdle;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

/* lcdLoadEngine.sv */
// Load sequencer: walks the window through the frame memory and feeds bytes to the transmitter
`timescale 1ns/10ps

module lcdLoadEngine
    import lcdRegPkg::*;
    import lcdLinkPkg::*;
(
    input  logic      WBs_CLK_i,
    input  logic      WBs_RST_i,
    input  logic      ctrlEn_i,
    input  logic      autoRefresh_i,
    input  slvAdr_t   slvAdr_i,
    input  fbRdAdr_t  winStart_i,
    input  loadLen_t  winLen_i,
    input  linkByte_t fbRdDat_i,
    input  logic      txReady_i,
    output logic      busy_o,
    output logic      loadDone_o,
    output logic      loadClr_o,
    output fbRdAdr_t  fbRdAdr_o,
    output linkByte_t txByte_o,
    output logic      txLast_o,
    output logic      txSend_o
);

    loadState_t loadState;
    fbRdAdr_t   curAdr;
    loadLen_t   remain;
    logic       canSend;

    assign busy_o    = (loadState != LoadIdle);
    assign fbRdAdr_o = curAdr;

    // Transmitter free and no send still in flight
    assign canSend = txReady_i & ~txSend_o;

    // ------------------------------------------------------------------------
    // Load FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            loadState  <= LoadIdle;
            curAdr     <= '0;
            remain     <= '0;
            txByte_o   <= '0;
            txLast_o   <= 1'b0;
            txSend_o   <= 1'b0;
            loadDone_o <= 1'b0;
            loadClr_o  <= 1'b0;
        end
        else
        begin
            // Single-cycle pulses
            txSend_o   <= 1'b0;
            loadDone_o <= 1'b0;
            loadClr_o  <= 1'b0;

            case (loadState)
                LoadIdle:
                begin
                    // Skip the cycle where the clear is still on its way
                    if (ctrlEn_i && !loadDone_o)
                    begin
                        curAdr    <= winStart_i;
                        remain    <= winLen_i;
                        loadState <= LoadAddress;
                    end
                end
                LoadAddress:
                if (canSend)
                begin
                    // Write direction, R/W bit 0
                    txByte_o  <= {slvAdr_i, 1'b0};
                    txLast_o  <= 1'b0;
                    txSend_o  <= 1'b1;
                    loadState <= LoadControl;
                end
                LoadControl:
                if (canSend)
                begin
                    txByte_o  <= DataCtrlByte;
                    txLast_o  <= (remain == '0);
                    txSend_o  <= 1'b1;
                    loadState <= (remain == '0) ? LoadFinish : LoadFetch;
                end
                // Memory read in flight
                LoadFetch:
                    loadState <= LoadData;
                LoadData:
                if (canSend)
                begin
                    txByte_o  <= fbRdDat_i;
                    txLast_o  <= (remain == loadLen_t'(1));
                    txSend_o  <= 1'b1;
                    // Wraps at the end of bank 2
                    curAdr    <= curAdr + 1'b1;
                    remain    <= remain - 1'b1;
                    loadState <= (remain == loadLen_t'(1)) ? LoadFinish : LoadFetch;
                end
                // Ready again only after the stop condition
                LoadFinish:
                if (canSend)
                begin
                    loadDone_o <= 1'b1;
                    loadClr_o  <= ~autoRefresh_i;
                    loadState  <= LoadIdle;
                end
                default:
                    loadState <= LoadIdle;
            endcase
        end
    end

    // Transmitter accepts a byte only while it signals ready
    sendWhenReady: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        txSend_o |-> txReady_i);

endmodule

/* lcdRegisters.sv */
// Wishbone register block: decodes host cycles, holds panel settings and the load-done interrupt
`timescale 1ns/10ps

module lcdRegisters
    import lcdRegPkg::*;
(
    input  logic     WBs_CLK_i,
    input  logic     WBs_RST_i,
    input  wbAdr_t   WBs_ADR_i,
    input  logic     WBs_CYC_i,
    input  logic     WBs_FB_CYC_i,
    input  logic     WBs_STB_i,
    input  logic     WBs_WE_i,
    input  byteStb_t WBs_BYTE_STB_i,
    input  wbDat_t   WBs_DAT_i,
    input  logic     busy_i,
    input  logic     loadDone_i,
    input  logic     loadClr_i,
    output wbDat_t   WBs_DAT_o,
    output logic     WBs_ACK_o,
    output logic     WBs_FB_ACK_o,
    output logic     ctrlEn_o,
    output logic     autoRefresh_o,
    output slvAdr_t  slvAdr_o,
    output fbRdAdr_t winStart_o,
    output loadLen_t winLen_o,
    output fbWrAdr_t fbWrAdr_o,
    output wbDat_t   fbWrDat_o,
    output logic     fbWrEn1_o,
    output logic     fbWrEn2_o,
    output logic     lcdLoadIrq_o
);

    logic   regWr;
    logic   ctrlWr;
    logic   fbWr;
    logic   irqEn;
    logic   loadDoneFlag;
    wbDat_t statusWord;
    wbDat_t controlWord;

    // ------------------------------------------------------------------------
    // Cycle decode
    // ------------------------------------------------------------------------
    // Register write, only with byte lane 0 set
    assign regWr  = WBs_CYC_i & WBs_STB_i & WBs_WE_i & ~WBs_ACK_o & WBs_BYTE_STB_i[0];
    assign ctrlWr = regWr & (WBs_ADR_i[3:0] == ControlRegAdr);

    // Frame memory write, bank from address bit 9
    assign fbWr      = WBs_FB_CYC_i & WBs_STB_i & WBs_WE_i & ~WBs_FB_ACK_o;
    assign fbWrEn1_o = fbWr & ~WBs_ADR_i[9];
    assign fbWrEn2_o = fbWr & WBs_ADR_i[9];
    assign fbWrAdr_o = WBs_ADR_i[8:0];
    assign fbWrDat_o = WBs_DAT_i;

    assign lcdLoadIrq_o = loadDoneFlag & irqEn;

    // ------------------------------------------------------------------------
    // Acknowledges and host registers
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            WBs_ACK_o     <= 1'b0;
            WBs_FB_ACK_o  <= 1'b0;
            ctrlEn_o      <= 1'b0;
            autoRefresh_o <= 1'b0;
            irqEn         <= 1'b0;
            loadDoneFlag  <= 1'b0;
            slvAdr_o      <= SlaveAdrReset;
            winStart_o    <= '0;
            winLen_o      <= '0;
        end
        else
        begin
            // One-cycle acknowledge, every access takes two cycles
            WBs_ACK_o    <= WBs_CYC_i & WBs_STB_i & ~WBs_ACK_o;
            WBs_FB_ACK_o <= WBs_FB_CYC_i & WBs_STB_i & ~WBs_FB_ACK_o;

            // Enables, cleared by the engine after a one-shot load
            if (ctrlWr)
            begin
                ctrlEn_o      <= WBs_DAT_i[CtrlEnBit];
                autoRefresh_o <= WBs_DAT_i[CtrlAutoBit];
                irqEn         <= WBs_DAT_i[CtrlIrqEnBit];
            end
            else if (loadClr_i)
            begin
                ctrlEn_o      <= 1'b0;
                autoRefresh_o <= 1'b0;
            end

            // Sticky done flag, a finishing load beats a host write
            if (loadDone_i)
                loadDoneFlag <= 1'b1;
            else if (ctrlWr)
                loadDoneFlag <= WBs_DAT_i[CtrlDoneBit];

            if (regWr && WBs_ADR_i[3:0] == SlaveAdrRegAdr)
                slvAdr_o <= WBs_DAT_i[6:0];

            if (regWr && WBs_ADR_i[3:0] == WindowRegAdr)
            begin
                winStart_o <= WBs_DAT_i[11:0];
                winLen_o   <= WBs_DAT_i[WinLenLsb +: $bits(loadLen_t)];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read-back
    // ------------------------------------------------------------------------
    always_comb
    begin
        statusWord                = '0;
        statusWord[StatBusyBit]   = busy_i;
        statusWord[StatDoneBit]   = loadDoneFlag;
        controlWord               = '0;
        controlWord[CtrlEnBit]    = ctrlEn_o;
        controlWord[CtrlAutoBit]  = autoRefresh_o;
        controlWord[CtrlIrqEnBit] = irqEn;
        controlWord[CtrlDoneBit]  = loadDoneFlag;

        // Frame memory is write only, returns zero
        if (WBs_FB_CYC_i)
            WBs_DAT_o = '0;
        else
        begin
            case (WBs_ADR_i[3:0])
                StatusRegAdr   : WBs_DAT_o = statusWord;
                ControlRegAdr  : WBs_DAT_o = controlWord;
                SlaveAdrRegAdr : WBs_DAT_o = wbDat_t'(slvAdr_o);
                WindowRegAdr   : WBs_DAT_o = wbDat_t'({winLen_o, 4'h0, winStart_o});
                default        : WBs_DAT_o = '0;
            endcase
        end
    end

    // Acknowledge pulses must let the host drop its strobe
    ackSingle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        (WBs_ACK_o || WBs_FB_ACK_o) |=> !(WBs_ACK_o || WBs_FB_ACK_o));

endmodule

/* lcdFrameBuffer.sv */
// Two-bank frame memory, filled by host word writes and read bytewise by the load engine
`timescale 1ns/10ps

module lcdFrameBuffer
    import lcdRegPkg::*;
    import lcdLinkPkg::*;
(
    input  logic      WBs_CLK_i,
    input  fbWrAdr_t  fbWrAdr_i,
    input  wbDat_t    fbWrDat_i,
    input  logic      fbWrEn1_i,
    input  logic      fbWrEn2_i,
    input  fbRdAdr_t  fbRdAdr_i,
    output linkByte_t fbRdDat_o
);

    // Bank 0 is host bank 1, bank 1 is host bank 2
    wbDat_t     fbMem [0:1][0:FbBankWords-1];

    // Registered read word and its lane select
    wbDat_t     rdWord;
    logic [1:0] rdLane;

    // ------------------------------------------------------------------------
    // Write port, one full word per access
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        if (fbWrEn1_i)
            fbMem[0][fbWrAdr_i] <= fbWrDat_i;
        if (fbWrEn2_i)
            fbMem[1][fbWrAdr_i] <= fbWrDat_i;
    end

    // ------------------------------------------------------------------------
    // Read port, one cycle latency
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        // Bank from bit 11, word from bits 10:2
        rdWord <= fbMem[fbRdAdr_i[11]][fbRdAdr_i[10:2]];
        rdLane <= fbRdAdr_i[1:0];
    end

    // Lane 0 is the lowest byte address
    assign fbRdDat_o = rdWord[{rdLane, 3'b000} +: 8];

endmodule

/* lcdLinkPkg.sv */
// Serial panel link timing, byte type and FSM encodings used by the load engine and transmitter
package lcdLinkPkg;

    typedef logic [7:0] linkByte_t;

    // Clocks per quarter bit, four quarters make one serial bit
    localparam int QuarterClks = 2;
    localparam int QuarterCntW = $clog2(QuarterClks) + 1;

    // Eight data bits plus the released acknowledge slot
    localparam int FrameBits = 9;

    // Panel control byte announcing a data stream
    localparam linkByte_t DataCtrlByte = 8'h40;

    // Transmitter FSM
    typedef enum logic [1:0] {TxIdle, TxStart, TxBit, TxStop} txState_t;

    // Load engine FSM
    typedef enum logic [2:0] {
        LoadIdle, LoadAddress, LoadControl, LoadFetch, LoadData, LoadFinish
    } loadState_t;

endpackage

/* lcdRegPkg.sv */
// Host register map, field widths and reset values shared by the register block and the top level
package lcdRegPkg;

    // ------------------------------------------------------------------------
    // Bus and memory widths
    // ------------------------------------------------------------------------
    typedef logic [9:0]  wbAdr_t;
    typedef logic [31:0] wbDat_t;
    typedef logic [3:0]  byteStb_t;

    // Byte address into frame memory, bit 11 picks the bank
    typedef logic [11:0] fbRdAdr_t;
    // Word address inside one bank
    typedef logic [8:0]  fbWrAdr_t;

    typedef logic [6:0]  slvAdr_t;
    typedef logic [7:0]  loadLen_t;

    // Words per frame memory bank
    localparam int FbBankWords = 512;

    // ------------------------------------------------------------------------
    // Register offsets on address bits 3:0
    // ------------------------------------------------------------------------
    localparam logic [3:0] StatusRegAdr   = 4'h0;
    localparam logic [3:0] ControlRegAdr  = 4'h1;
    localparam logic [3:0] SlaveAdrRegAdr = 4'h3;
    localparam logic [3:0] WindowRegAdr   = 4'h4;

    // Status fields
    localparam int StatBusyBit = 0;
    localparam int StatDoneBit = 1;

    // Control fields
    localparam int CtrlEnBit    = 0;
    localparam int CtrlAutoBit  = 1;
    localparam int CtrlIrqEnBit = 2;
    localparam int CtrlDoneBit  = 3;

    // Window fields
    localparam int WinLenLsb = 16;

    // Default panel address, 0x78 on the wire once shifted
    localparam slvAdr_t SlaveAdrReset = 7'h3C;

endpackage
